// File: pixel_out.sv
// ------------------------------
// black while blanking, RGB565 zero-padded to 8 bits
// ------------------------------
`timescale 1ns/100ps

module pixel_out (
  input  logic             clk,
  input  logic             reset,
  fetch_if.sink            fetch,
  input  vga_pkg::rgb565_t apple_data,
  input  vga_pkg::rgb565_t head_data,
  input  vga_pkg::rgb565_t wall_data,
  output logic [7:0]       vga_r,
  output logic [7:0]       vga_g,
  output logic [7:0]       vga_b,
  output logic             vga_hs,
  output logic             vga_vs,
  output logic             vga_blank_n,
  output logic             vga_clk
);
  import vga_pkg::*;

  object_e object_d;
  logic    blank_n_d;
  logic    hs_d;
  logic    vs_d;
  logic    pix_clk_d;
  rgb565_t word;

  // ------------------------------
  // wait out the ROM read
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      object_d  <= obj_background;
      blank_n_d <= 1'b0;
      hs_d      <= 1'b0;
      vs_d      <= 1'b0;
      pix_clk_d <= 1'b0;
    end else begin
      object_d  <= fetch.object;
      blank_n_d <= fetch.blank_n;
      hs_d      <= fetch.hs;
      vs_d      <= fetch.vs;
      pix_clk_d <= fetch.pix_clk;
    end
  end

  // pick the ROM word for the tagged object
  always_comb begin
    case (object_d)
      obj_apple: word = apple_data;
      obj_head:  word = head_data;
      obj_wall:  word = wall_data;
      default:   word = '0;
    endcase
  end

  // ------------------------------
  // output registers
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vga_r       <= '0;
      vga_g       <= '0;
      vga_b       <= '0;
      vga_hs      <= 1'b0;
      vga_vs      <= 1'b0;
      vga_blank_n <= 1'b0;
      vga_clk     <= 1'b0;
    end else begin
      // zero outside the active area
      vga_r       <= blank_n_d ? {word.r, 3'b000} : 8'h00;
      vga_g       <= blank_n_d ? {word.g, 2'b00} : 8'h00;
      vga_b       <= blank_n_d ? {word.b, 3'b000} : 8'h00;
      vga_hs      <= hs_d;
      vga_vs      <= vs_d;
      vga_blank_n <= blank_n_d;
      vga_clk     <= pix_clk_d;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_vga_ball \
  --Mdir obj_dir -o tb_vga_ball_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_vga_ball_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: sim.f
vga_pkg.sv
vga_if.sv
vga_timing.sv
vga_regs.sv
tile_select.sv
sprite_rom.sv
pixel_out.sv
vga_ball.sv
tb_clock.sv
tb_vga_ball.sv

// File: sprite_rom.sv
// ------------------------------
// registered read, contents fixed at start-up
// ------------------------------
`timescale 1ns/100ps

module sprite_rom #(
  parameter int               depth = 256,
  parameter vga_pkg::object_e kind  = vga_pkg::obj_wall
) (
  input  logic             clk,
  input  logic [9:0]       addr,
  output vga_pkg::rgb565_t data
);
  import vga_pkg::*;

  // low address bits index the array
  localparam int addr_bits = $clog2(depth);

  rgb565_t mem [depth];

  // fill from the colour rule for this sprite
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = sprite_color(kind, 10'(i));
    end
  end

  // one word per cycle
  always_ff @(posedge clk) begin
    data <= mem[addr[addr_bits-1:0]];
  end

endmodule

// File: tb_clock.sv
// ------------------------------
// free running clock, reset held for a fixed count
// ------------------------------
`timescale 1ns/100ps

module tb_clock #(
  parameter real period       = 4.0,
  parameter int  reset_cycles = 10
) (
  output logic clk,
  output logic reset
);

  initial clk = 1'b0;
  always #(period / 2.0) clk = ~clk;

  // release just after a rising edge
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
  end

endmodule

// File: tb_vga_ball.sv
// ------------------------------
// checks every output cycle against a pixel model
// sprite cells kept away from the screen edge
// ------------------------------
`timescale 1ns/100ps

module tb_vga_ball;

  // line and frame lengths in clk cycles
  localparam int    line_cycles  = 1600;
  localparam int    frame_cycles = 1600 * 525;
  localparam int    test_frames  = 5;
  localparam real   clk_period   = 4.0;
  localparam real   watchdog_ns  = (test_frames + 1) * frame_cycles * clk_period;
  localparam int    num_tests    = 5;
  localparam int    max_printed  = 10;

  logic       clk;
  logic       reset;
  logic [7:0] writedata;
  logic       write;
  logic       chipselect;
  logic [2:0] address;
  logic [7:0] VGA_R;
  logic [7:0] VGA_G;
  logic [7:0] VGA_B;
  logic       VGA_CLK;
  logic       VGA_HS;
  logic       VGA_VS;
  logic       VGA_BLANK_n;

  // model of what should be on screen
  bit          apple_on;
  bit          head_on;
  int          apple_col;
  int          apple_row;
  int          head_col;
  int          head_row;
  logic [15:0] lfsr;

  // per test error counts with timing at index 0
  string test_names [num_tests];
  int    test_errors [num_tests];
  int    current_test;

  // pixel position tracker
  int          hcycle;
  int          line_idx;
  logic        px_prev_blank;
  logic        px_prev_vs;
  logic [23:0] actual_rgb;
  logic [23:0] expect_rgb;

  // timing monitor state
  int   blank_run;
  int   hs_low_run;
  int   vs_low_run;
  int   line_len;
  int   frame_len;
  int   line_checks;
  int   frame_checks;
  bit   hs_fell;
  bit   vs_fell;
  logic tm_prev_blank;
  logic tm_prev_hs;
  logic tm_prev_vs;

  int total_errors;
  int failed_tests;

  tb_clock #(.period(clk_period), .reset_cycles(10)) clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  vga_ball DUT (
    .clk         (clk),
    .reset       (reset),
    .writedata   (writedata),
    .write       (write),
    .chipselect  (chipselect),
    .address     (address),
    .VGA_R       (VGA_R),
    .VGA_G       (VGA_G),
    .VGA_B       (VGA_B),
    .VGA_CLK     (VGA_CLK),
    .VGA_HS      (VGA_HS),
    .VGA_VS      (VGA_VS),
    .VGA_BLANK_n (VGA_BLANK_n)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  // 16 bit galois lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic take_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // sprite cell within columns 2..18 and rows 3..12
  task automatic pick_cell(output int col, output int row);
    int value;
    take_bits(5, value);
    col = 2 + value % 17;
    take_bits(4, value);
    row = 3 + value % 10;
  endtask

  // expected {R,G,B} for one active pixel
  function automatic logic [23:0] expected_rgb(int col, int row);
    int         sc;
    int         sr;
    int         tc;
    int         tr;
    logic [7:0] green;
    sc = col / 16;
    sr = row / 16;
    tc = col / 32;
    tr = row / 32;
    // sprite green is {row mod 16, column bits 3..2} shifted up two
    green = 8'(((row % 16) * 4 + (col % 16) / 4) * 4);
    if (apple_on && sc == apple_col && sr == apple_row) begin
      return {8'hF8, green, 8'h00};
    end
    if (head_on && sc == head_col && sr == head_row) begin
      return {8'h00, green, 8'hF8};
    end
    if (((tc == 0 || tc == 19) && tr > 1) || tr == 1 || tr == 14) begin
      return {8'((col % 32) * 8), 8'hFC, 8'((row % 32) * 8)};
    end
    return 24'h000000;
  endfunction

  task automatic bus_write(input logic [2:0] addr, input logic [7:0] data);
    @(posedge clk);
    #1;
    chipselect = 1'b1;
    write      = 1'b1;
    address    = addr;
    writedata  = data;
    @(posedge clk);
    #1;
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  task automatic check_count(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      if (test_errors[0] < max_printed) begin
        $display("error: timing %s expected %0d actual %0d", what, expected, actual);
      end
      test_errors[0]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %s: %s, %0d errors", test_names[t],
             (test_errors[t] == 0) ? "pass" : "fail", test_errors[t]);
  endtask

  // ------------------------------
  // pixel monitor
  // ------------------------------
  always @(negedge clk) begin
    if (reset) begin
      hcycle        = 0;
      line_idx      = -1;
      px_prev_blank = 1'b0;
      px_prev_vs    = 1'b0;
    end else begin
      // frame restarts at vsync fall and line at blank rise
      if (px_prev_vs && !VGA_VS) line_idx = -1;
      if (VGA_BLANK_n && !px_prev_blank) begin
        line_idx++;
        hcycle = 0;
      end else if (VGA_BLANK_n) begin
        hcycle++;
      end
      actual_rgb = {VGA_R, VGA_G, VGA_B};
      expect_rgb = VGA_BLANK_n ? expected_rgb(hcycle / 2, line_idx) : 24'h000000;
      assert (actual_rgb == expect_rgb) else begin
        if (test_errors[current_test] < max_printed) begin
          $display("error: %s pixel x=%0d y=%0d blank_n=%b expected %06h actual %06h",
                   test_names[current_test], hcycle / 2, line_idx, VGA_BLANK_n,
                   expect_rgb, actual_rgb);
        end
        test_errors[current_test]++;
      end
      px_prev_blank = VGA_BLANK_n;
      px_prev_vs    = VGA_VS;
    end
  end

  // ------------------------------
  // timing monitor
  // ------------------------------
  always @(negedge clk) begin
    if (reset) begin
      blank_run     = 0;
      hs_low_run    = 0;
      vs_low_run    = 0;
      line_len      = 0;
      frame_len     = 0;
      hs_fell       = 1'b0;
      vs_fell       = 1'b0;
      tm_prev_blank = 1'b0;
      tm_prev_hs    = 1'b0;
      tm_prev_vs    = 1'b0;
    end else begin
      line_len++;
      frame_len++;
      // active run length and pixel clock phase inside it
      if (VGA_BLANK_n) begin
        blank_run++;
        assert (VGA_CLK == ((blank_run % 2) == 0)) else begin
          if (test_errors[0] < max_printed) begin
            $display("error: timing VGA_CLK expected %b actual %b in active cycle %0d",
                     (blank_run % 2) == 0, VGA_CLK, blank_run);
          end
          test_errors[0]++;
        end
      end else if (tm_prev_blank) begin
        check_count("active cycles", 1280, blank_run);
        blank_run = 0;
      end
      // hsync width and line period once a fall was seen
      if (tm_prev_hs && !VGA_HS) begin
        if (hs_fell) begin
          check_count("line period", line_cycles, line_len);
          line_checks++;
        end
        hs_fell    = 1'b1;
        line_len   = 0;
        hs_low_run = 0;
      end
      if (!VGA_HS) hs_low_run++;
      else if (!tm_prev_hs && hs_fell) check_count("hsync low cycles", 192, hs_low_run);
      // vsync width and frame period
      if (tm_prev_vs && !VGA_VS) begin
        if (vs_fell) begin
          check_count("frame period", frame_cycles, frame_len);
          frame_checks++;
        end
        vs_fell    = 1'b1;
        frame_len  = 0;
        vs_low_run = 0;
      end
      if (!VGA_VS) begin
        vs_low_run++;
      end else if (!tm_prev_vs && vs_fell) begin
        check_count("vsync low cycles", 2 * line_cycles, vs_low_run);
      end
      tm_prev_blank = VGA_BLANK_n;
      tm_prev_hs    = VGA_HS;
      tm_prev_vs    = VGA_VS;
    end
  end

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    #(watchdog_ns);
    $display("timeout: the frame sequence did not complete in time");
    $display("Finished with errors");
    $finish;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin
    writedata    = 8'h00;
    write        = 1'b0;
    chipselect   = 1'b0;
    address      = 3'd0;
    lfsr         = 16'd35461;
    apple_on     = 1'b0;
    head_on      = 1'b0;
    apple_col    = 0;
    apple_row    = 0;
    head_col     = 0;
    head_row     = 0;
    line_checks  = 0;
    frame_checks = 0;
    test_names   = '{"timing", "reset_blank", "wall", "apple", "head_priority"};
    test_errors  = '{default: 0};
    current_test = 1;

    @(negedge reset);
    // first frame shows wall and black only
    @(negedge VGA_VS);
    report_test(1);
    current_test = 2;
    @(negedge VGA_VS);
    report_test(2);

    // apple placed during vertical blanking
    pick_cell(apple_col, apple_row);
    bus_write(vga_pkg::addr_x, 8'(apple_col));
    bus_write(vga_pkg::addr_y, 8'(apple_row));
    bus_write(vga_pkg::addr_cmd, 8'(vga_pkg::cmd_apple));
    apple_on     = 1'b1;
    current_test = 3;
    @(negedge VGA_VS);
    report_test(3);

    // head command first so the apple latch stops following
    pick_cell(head_col, head_row);
    while (head_col == apple_col && head_row == apple_row) pick_cell(head_col, head_row);
    bus_write(vga_pkg::addr_cmd, 8'(vga_pkg::cmd_head_right));
    bus_write(vga_pkg::addr_x, 8'(head_col));
    bus_write(vga_pkg::addr_y, 8'(head_row));
    head_on      = 1'b1;
    current_test = 4;
    @(negedge VGA_VS);

    // head onto the apple cell where apple must win
    bus_write(vga_pkg::addr_x, 8'(apple_col));
    bus_write(vga_pkg::addr_y, 8'(apple_row));
    head_col = apple_col;
    head_row = apple_row;
    @(negedge VGA_VS);
    report_test(4);

    // timing monitor has seen several full frames by now
    assert (line_checks > 0 && frame_checks > 0) else begin
      $display("timing monitor never saw a complete line and frame");
      test_errors[0]++;
    end
    report_test(0);

    total_errors = 0;
    failed_tests = 0;
    for (int t = 0; t < num_tests; t++) begin
      total_errors += test_errors[t];
      if (test_errors[t] != 0) failed_tests++;
    end
    $display("tests %0d, failed %0d, errors %0d", num_tests, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tile_select.sv
// ------------------------------
// one cycle; priority apple, head, wall, black
// apple hidden until first placed after reset
// ------------------------------
`timescale 1ns/100ps

module tile_select (
  input  logic                 clk,
  input  logic                 reset,
  scan_if.sink                 scan,
  input  logic [7:0]           x_pos,
  input  logic [7:0]           y_pos,
  input  logic [7:0]           apple_x,
  input  logic [7:0]           apple_y,
  input  vga_pkg::sprite_cmd_e cmd,
  fetch_if.source              fetch
);
  import vga_pkg::*;

  // log2 of cell sizes, 4 and 5
  localparam int sprite_bits = $clog2(sprite_size);
  localparam int wall_bits   = $clog2(wall_size);

  logic [9:0] column;
  logic [9:0] row;
  logic [5:0] sprite_col;
  logic [5:0] sprite_row;
  logic [4:0] tile_col;
  logic [4:0] tile_row;
  logic       apple_placed;
  logic       apple_hit;
  logic       head_hit;
  logic       wall_hit;
  object_e    object_next;

  // pixel column drops the half-pixel bit
  assign column = scan.hcount[10:1];
  assign row    = scan.vcount;

  // 16 pixel sprite cells and 32 pixel wall tiles
  assign sprite_col = column[9:sprite_bits];
  assign sprite_row = row[9:sprite_bits];
  assign tile_col   = column[9:wall_bits];
  assign tile_row   = row[9:wall_bits];

  // set on the first apple command
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      apple_placed <= 1'b0;
    end else if (cmd == cmd_apple) begin
      apple_placed <= 1'b1;
    end
  end

  // ------------------------------
  // hit tests
  // ------------------------------
  assign apple_hit = apple_placed &&
                     (sprite_col == apple_x[5:0]) && (sprite_row == apple_y[5:0]);

  // head only shown under its own command
  assign head_hit = (cmd == cmd_head_right) &&
                    (sprite_col == x_pos[5:0]) && (sprite_row == y_pos[5:0]);

  // side walls skip the top row, top and bottom span the width
  assign wall_hit = (((tile_col == 5'd0) || (tile_col == wall_cols - 5'd1)) &&
                     (tile_row > 5'd1)) ||
                    (tile_row == 5'd1) || (tile_row == wall_rows - 5'd1);

  always_comb begin
    if (apple_hit) begin
      object_next = obj_apple;
    end else if (head_hit) begin
      object_next = obj_head;
    end else if (wall_hit) begin
      object_next = obj_wall;
    end else begin
      object_next = obj_background;
    end
  end

  // ------------------------------
  // output stage
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fetch.object     <= obj_background;
      fetch.apple_addr <= '0;
      fetch.head_addr  <= '0;
      fetch.wall_addr  <= '0;
      fetch.blank_n    <= 1'b0;
      fetch.hs         <= 1'b0;
      fetch.vs         <= 1'b0;
      fetch.pix_clk    <= 1'b0;
    end else begin
      fetch.object     <= object_next;
      // row major within the cell
      fetch.apple_addr <= {row[sprite_bits-1:0], column[sprite_bits-1:0]};
      fetch.head_addr  <= {row[sprite_bits-1:0], column[sprite_bits-1:0]};
      fetch.wall_addr  <= {row[wall_bits-1:0], column[wall_bits-1:0]};
      fetch.blank_n    <= scan.blank_n;
      fetch.hs         <= scan.hs;
      fetch.vs         <= scan.vs;
      fetch.pix_clk    <= scan.pix_clk;
    end
  end

endmodule

// File: vga_ball.sv
// ------------------------------
// outputs trail the scan counters by 3 clk cycles
// ------------------------------
`timescale 1ns/100ps

module vga_ball #(
  parameter vga_pkg::hcount_t h_active = vga_pkg::h_active,
  parameter vga_pkg::hcount_t h_front  = vga_pkg::h_front,
  parameter vga_pkg::hcount_t h_sync   = vga_pkg::h_sync,
  parameter vga_pkg::hcount_t h_back   = vga_pkg::h_back,
  parameter vga_pkg::vcount_t v_active = vga_pkg::v_active,
  parameter vga_pkg::vcount_t v_front  = vga_pkg::v_front,
  parameter vga_pkg::vcount_t v_sync   = vga_pkg::v_sync,
  parameter vga_pkg::vcount_t v_back   = vga_pkg::v_back
) (
  input  logic       clk,
  input  logic       reset,
  input  logic [7:0] writedata,
  input  logic       write,
  input  logic       chipselect,
  input  logic [2:0] address,
  output logic [7:0] VGA_R,
  output logic [7:0] VGA_G,
  output logic [7:0] VGA_B,
  output logic       VGA_CLK,
  output logic       VGA_HS,
  output logic       VGA_VS,
  output logic       VGA_BLANK_n
);
  import vga_pkg::*;

  logic [7:0]  x_pos;
  logic [7:0]  y_pos;
  logic [7:0]  apple_x;
  logic [7:0]  apple_y;
  sprite_cmd_e cmd;
  rgb565_t     apple_word;
  rgb565_t     head_word;
  rgb565_t     wall_word;

  scan_if  scan ();
  fetch_if fetch ();

  // ------------------------------
  // scan and registers
  // ------------------------------
  vga_timing #(
    .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
    .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
  ) timing (
    .clk   (clk),
    .reset (reset),
    .scan  (scan.source)
  );

  vga_regs regs (
    .clk        (clk),
    .reset      (reset),
    .writedata  (writedata),
    .write      (write),
    .chipselect (chipselect),
    .address    (address),
    .x_pos      (x_pos),
    .y_pos      (y_pos),
    .cmd        (cmd),
    .apple_x    (apple_x),
    .apple_y    (apple_y)
  );

  // ------------------------------
  // pixel pipeline
  // ------------------------------
  tile_select select (
    .clk     (clk),
    .reset   (reset),
    .scan    (scan.sink),
    .x_pos   (x_pos),
    .y_pos   (y_pos),
    .apple_x (apple_x),
    .apple_y (apple_y),
    .cmd     (cmd),
    .fetch   (fetch.source)
  );

  // sprite ROMs take 8 bit addresses, top bits zero
  sprite_rom #(.depth(256), .kind(obj_apple)) apple_rom (
    .clk  (clk),
    .addr ({2'b00, fetch.apple_addr}),
    .data (apple_word)
  );

  sprite_rom #(.depth(256), .kind(obj_head)) head_rom (
    .clk  (clk),
    .addr ({2'b00, fetch.head_addr}),
    .data (head_word)
  );

  sprite_rom #(.depth(1024), .kind(obj_wall)) wall_rom (
    .clk  (clk),
    .addr (fetch.wall_addr),
    .data (wall_word)
  );

  pixel_out out (
    .clk         (clk),
    .reset       (reset),
    .fetch       (fetch.sink),
    .apple_data  (apple_word),
    .head_data   (head_word),
    .wall_data   (wall_word),
    .vga_r       (VGA_R),
    .vga_g       (VGA_G),
    .vga_b       (VGA_B),
    .vga_hs      (VGA_HS),
    .vga_vs      (VGA_VS),
    .vga_blank_n (VGA_BLANK_n),
    .vga_clk     (VGA_CLK)
  );

endmodule

// File: vga_if.sv
// ------------------------------
// scan and fetch buses between the pipeline stages
// ------------------------------
`timescale 1ns/100ps

// raw scan position plus its decodes
interface scan_if;
  import vga_pkg::*;

  hcount_t hcount;
  vcount_t vcount;
  logic    blank_n;
  logic    hs;
  logic    vs;
  // pixel clock is hcount bit 0
  logic    pix_clk;

  modport source (output hcount, vcount, blank_n, hs, vs, pix_clk);
  modport sink   (input  hcount, vcount, blank_n, hs, vs, pix_clk);
endinterface

// object tag, ROM addresses and syncs, one stage late
interface fetch_if;
  import vga_pkg::*;

  object_e    object;
  logic [7:0] apple_addr;
  logic [7:0] head_addr;
  logic [9:0] wall_addr;
  logic       blank_n;
  logic       hs;
  logic       vs;
  logic       pix_clk;

  modport source (
    output object, apple_addr, head_addr, wall_addr,
    output blank_n, hs, vs, pix_clk
  );
  modport sink (
    input object, apple_addr, head_addr, wall_addr,
    input blank_n, hs, vs, pix_clk
  );
endinterface

// File: vga_pkg.sv
// ------------------------------
// 640x480 at 50 MHz, two clk cycles per pixel
// sprite colours come from a fixed rule, not image data
// ------------------------------
package vga_pkg;

  // counter types
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

  // horizontal, in clk cycles
  localparam hcount_t h_active = 11'd1280;
  localparam hcount_t h_front  = 11'd32;
  localparam hcount_t h_sync   = 11'd192;
  localparam hcount_t h_back   = 11'd96;
  localparam hcount_t h_total  = 11'd1600;

  // vertical, in lines
  localparam vcount_t v_active = 10'd480;
  localparam vcount_t v_front  = 10'd10;
  localparam vcount_t v_sync   = 10'd2;
  localparam vcount_t v_back   = 10'd33;
  localparam vcount_t v_total  = 10'd525;

  // grid, in pixels and tiles
  localparam logic [5:0] sprite_size = 6'd16;
  localparam logic [5:0] wall_size   = 6'd32;
  localparam logic [4:0] wall_cols   = 5'd20;
  localparam logic [4:0] wall_rows   = 5'd15;

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef enum logic [2:0] {
    addr_x   = 3'd0,
    addr_y   = 3'd1,
    addr_cmd = 3'd2
  } reg_addr_e;

  typedef enum logic [7:0] {
    cmd_none       = 8'd0,
    cmd_apple      = 8'd1,
    cmd_head_right = 8'd2
  } sprite_cmd_e;

  typedef enum logic [1:0] {
    obj_background,
    obj_wall,
    obj_apple,
    obj_head
  } object_e;

  // stand-in image data, shared by the ROMs and the checker
  function automatic rgb565_t sprite_color(object_e kind, logic [9:0] addr);
    rgb565_t word;
    word = '0;
    case (kind)
      obj_wall: begin
        word.r = addr[4:0];
        word.g = '1;
        word.b = addr[9:5];
      end
      obj_apple: begin
        word.r = '1;
        word.g = addr[7:2];
      end
      obj_head: begin
        word.g = addr[7:2];
        word.b = '1;
      end
      default: word = '0;
    endcase
    return word;
  endfunction

endpackage

// File: vga_regs.sv
// ------------------------------
// write only, addresses 3 to 7 ignored
// ------------------------------
`timescale 1ns/100ps

module vga_regs (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [7:0]           writedata,
  input  logic                 write,
  input  logic                 chipselect,
  input  logic [2:0]           address,
  output logic [7:0]           x_pos,
  output logic [7:0]           y_pos,
  output vga_pkg::sprite_cmd_e cmd,
  output logic [7:0]           apple_x,
  output logic [7:0]           apple_y
);
  import vga_pkg::*;

  // bus register bank
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      x_pos <= '0;
      y_pos <= '0;
      cmd   <= cmd_none;
    end else if (chipselect && write) begin
      case (reg_addr_e'(address))
        addr_x:   x_pos <= writedata;
        addr_y:   y_pos <= writedata;
        addr_cmd: cmd   <= sprite_cmd_e'(writedata);
        default:  ;
      endcase
    end
  end

  // apple follows x and y while the apple command is up
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      apple_x <= '0;
      apple_y <= '0;
    end else if (cmd == cmd_apple) begin
      apple_x <= x_pos;
      apple_y <= y_pos;
    end
  end

endmodule

// File: vga_timing.sv
// ------------------------------
// syncs are active low, decodes are combinational
// ------------------------------
`timescale 1ns/100ps

module vga_timing #(
  parameter vga_pkg::hcount_t h_active = vga_pkg::h_active,
  parameter vga_pkg::hcount_t h_front  = vga_pkg::h_front,
  parameter vga_pkg::hcount_t h_sync   = vga_pkg::h_sync,
  parameter vga_pkg::hcount_t h_back   = vga_pkg::h_back,
  parameter vga_pkg::vcount_t v_active = vga_pkg::v_active,
  parameter vga_pkg::vcount_t v_front  = vga_pkg::v_front,
  parameter vga_pkg::vcount_t v_sync   = vga_pkg::v_sync,
  parameter vga_pkg::vcount_t v_back   = vga_pkg::v_back
) (
  input logic    clk,
  input logic    reset,
  scan_if.source scan
);
  import vga_pkg::*;

  // last count of a line and of a frame
  localparam hcount_t h_last = h_active + h_front + h_sync + h_back - 11'd1;
  localparam vcount_t v_last = v_active + v_front + v_sync + v_back - 10'd1;

  // sync windows, end exclusive
  localparam hcount_t hs_start = h_active + h_front;
  localparam hcount_t hs_end   = h_active + h_front + h_sync;
  localparam vcount_t vs_start = v_active + v_front;
  localparam vcount_t vs_end   = v_active + v_front + v_sync;

  hcount_t hcount;
  vcount_t vcount;
  logic    end_of_line;
  logic    end_of_frame;

  assign end_of_line  = (hcount == h_last);
  assign end_of_frame = (vcount == v_last);

  // ------------------------------
  // counters
  // ------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // line count steps once per line end
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_frame) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  // ------------------------------
  // decodes
  // ------------------------------
  assign scan.hcount  = hcount;
  assign scan.vcount  = vcount;
  assign scan.hs      = !((hcount >= hs_start) && (hcount < hs_end));
  assign scan.vs      = !((vcount >= vs_start) && (vcount < vs_end));
  assign scan.blank_n = (hcount < h_active) && (vcount < v_active);
  // 25 MHz, rising edge mid pixel
  assign scan.pix_clk = hcount[0];

endmodule
